//--- verilog/ternary_pkg.sv
// Ternary accelerator definitions
package ternary_pkg;

    // frame geometry
    // bytes gathered per frame, also the depth of each row ring
    localparam int compute_slices = 2;

    // slice counter width, never below one bit
    localparam int slice_bits = (compute_slices > 1) ? $clog2(compute_slices) : 1;

    // five base-3 weights fit in one byte since 3^5 = 243
    localparam int lanes_per_byte = 5;

    // one row per weight lane of every byte in the frame
    localparam int array_rows = lanes_per_byte * compute_slices;

    // total accumulators across all row rings
    localparam int acc_count = array_rows * compute_slices;

    // datapath widths
    localparam int acc_width = 17;
    localparam int byte_width = 8;

    // readout takes the byte just above this many low bits
    localparam int result_shift = 8;

    // largest code that is still a valid five-digit base-3 value
    localparam int max_weight_code = 242;

    // signed accumulator
    typedef logic signed [acc_width-1:0] acc_t;

    // zero or sign flag per lane of one packed byte
    typedef logic [lanes_per_byte-1:0] lane_mask_t;

    // zero or sign flag per array row
    typedef logic [array_rows-1:0] row_mask_t;

    // activation bytes of one frame, byte n at bits n*8 upward
    typedef logic [compute_slices*byte_width-1:0] frame_t;

    // position inside the frame
    typedef logic [slice_bits-1:0] slice_t;

endpackage

//--- verilog/weight_unpacker.sv
// Base-3 weight unpacker
`timescale 1ns/1ps

module weight_unpacker (
    input  logic [ternary_pkg::byte_width-1:0] packed_weights,
    output ternary_pkg::lane_mask_t            weight_zero,
    output ternary_pkg::lane_mask_t            weight_sign
);

    // digit encoding
    //   0 -> weight 0
    //   1 -> weight +1
    //   2 -> weight -1
    // digit k (weight 3^k) lands on lane 4-k, so the most
    // significant digit drives lane 0

    always_comb begin
        logic [ternary_pkg::byte_width-1:0] remainder;
        logic [1:0]                         digit;

        remainder = packed_weights;
        digit = 2'd0;
        weight_zero = '0;
        weight_sign = '0;

        // peel off one base-3 digit per lane, lowest digit first
        // constant divisor keeps this a small fixed network
        for (int k = 0; k < ternary_pkg::lanes_per_byte; k++) begin
            digit = 2'(remainder % 8'd3);
            remainder = remainder / 8'd3;
            weight_zero[ternary_pkg::lanes_per_byte-1-k] = (digit == 2'd0);
            weight_sign[ternary_pkg::lanes_per_byte-1-k] = (digit == 2'd2);
        end

        // codes 243..255 carry no valid digits
        // all flags low means every lane acts as +1
        if (packed_weights > ternary_pkg::max_weight_code) begin
            weight_zero = '0;
            weight_sign = '0;
        end
    end

    // quick sanity values
    //   code 1   -> lane 4 is +1, rest zero
    //   code 2   -> lane 4 is -1, rest zero
    //   code 121 -> all lanes +1
    //   code 242 -> all lanes -1

endmodule

//--- verilog/input_stager.sv
// Frame input stager
`timescale 1ns/1ps

module input_stager (
    input  logic                               clk,
    input  logic                               reset,
    input  logic                               compute,
    input  ternary_pkg::lane_mask_t            weight_zero,
    input  ternary_pkg::lane_mask_t            weight_sign,
    input  logic [ternary_pkg::byte_width-1:0] activation,
    output ternary_pkg::row_mask_t             row_zero,
    output ternary_pkg::row_mask_t             row_sign,
    output ternary_pkg::frame_t                frame,
    output ternary_pkg::slice_t                slice
);

    // frame being filled, one byte per cycle
    ternary_pkg::row_mask_t next_zero;
    ternary_pkg::row_mask_t next_sign;
    ternary_pkg::frame_t    next_frame;

    // high on the final byte of a frame
    logic slice_last;

    assign slice_last = (slice == ternary_pkg::slice_t'(ternary_pkg::compute_slices - 1));

    // slice counter
    // restarts on reset and whenever compute drops, otherwise wraps
    always_ff @(posedge clk) begin
        if (reset || !compute || slice_last) begin
            slice <= '0;
        end else begin
            slice <= slice + 1'b1;
        end
    end

    // fill side of the double buffer
    // lane group and byte are picked by the current slice
    always_ff @(posedge clk) begin
        if (reset) begin
            next_zero  <= '0;
            next_sign  <= '0;
            next_frame <= '0;
        end else begin
            next_zero[slice*ternary_pkg::lanes_per_byte +: ternary_pkg::lanes_per_byte]
                <= weight_zero;
            next_sign[slice*ternary_pkg::lanes_per_byte +: ternary_pkg::lanes_per_byte]
                <= weight_sign;
            next_frame[slice*ternary_pkg::byte_width +: ternary_pkg::byte_width]
                <= activation;
        end
    end

    // compute side of the double buffer
    // swaps at slice 0, taking the previous contents of the fill side,
    // so the array sees one frame unchanged for a whole ring turn
    always_ff @(posedge clk) begin
        if (slice == '0) begin
            row_zero <= next_zero;
            row_sign <= next_sign;
            frame    <= next_frame;
        end
    end

endmodule

//--- verilog/mac_array.sv
// Ternary MAC ring array
`timescale 1ns/1ps

module mac_array (
    input  logic                   clk,
    input  logic                   reset,
    input  logic                   compute,
    input  ternary_pkg::row_mask_t row_zero,
    input  ternary_pkg::row_mask_t row_sign,
    input  ternary_pkg::frame_t    frame,
    input  ternary_pkg::slice_t    slice,
    output ternary_pkg::acc_t      acc_next [ternary_pkg::acc_count]
);

    // accumulator storage, index is row * compute_slices + column
    ternary_pkg::acc_t acc_q [ternary_pkg::acc_count];

    // activation byte for this slice
    logic [ternary_pkg::byte_width-1:0] act_byte;

    // same byte sign extended to accumulator width
    ternary_pkg::acc_t addend;

    assign act_byte = frame[slice*ternary_pkg::byte_width +: ternary_pkg::byte_width];

    // activations are signed bytes
    assign addend = {{(ternary_pkg::acc_width - ternary_pkg::byte_width)
                      {act_byte[ternary_pkg::byte_width-1]}}, act_byte};

    for (genvar r = 0; r < ternary_pkg::array_rows; r++) begin : g_row
        // column 0 of this row's ring
        ternary_pkg::acc_t head;
        // head after the ternary update
        ternary_pkg::acc_t head_sum;

        assign head = acc_q[r*ternary_pkg::compute_slices];

        // weight 0 leaves the head alone
        // weight -1 subtracts, weight +1 adds
        always_comb begin
            if (row_zero[r]) begin
                head_sum = head;
            end else if (row_sign[r]) begin
                head_sum = head - addend;
            end else begin
                head_sum = head + addend;
            end
        end

        // updated head goes to the tail of the ring
        assign acc_next[r*ternary_pkg::compute_slices + ternary_pkg::compute_slices - 1] =
            head_sum;

        // remaining columns move one step toward the head
        for (genvar c = 0; c < ternary_pkg::compute_slices - 1; c++) begin : g_col
            assign acc_next[r*ternary_pkg::compute_slices + c] =
                acc_q[r*ternary_pkg::compute_slices + c + 1];
        end
    end

    // ring registers
    // compute low clears every ring so the next pass starts from zero
    always_ff @(posedge clk) begin
        for (int n = 0; n < ternary_pkg::acc_count; n++) begin
            if (reset || !compute) begin
                acc_q[n] <= '0;
            end else begin
                acc_q[n] <= acc_next[n];
            end
        end
    end

endmodule

//--- verilog/readout_queue.sv
// Accumulator readout queue
`timescale 1ns/1ps

module readout_queue (
    input  logic                               clk,
    input  logic                               reset,
    input  logic                               compute,
    input  ternary_pkg::acc_t                  acc_next [ternary_pkg::acc_count],
    output logic [ternary_pkg::byte_width-1:0] result_out
);

    // one entry per accumulator, entry 0 faces the output
    ternary_pkg::acc_t queue_q [ternary_pkg::acc_count];

    // compute low captures this cycle's updated accumulators
    // compute high shifts toward entry 0, last entry keeps its value
    always_ff @(posedge clk) begin
        if (reset) begin
            for (int n = 0; n < ternary_pkg::acc_count; n++) begin
                queue_q[n] <= '0;
            end
        end else if (!compute) begin
            for (int n = 0; n < ternary_pkg::acc_count; n++) begin
                queue_q[n] <= acc_next[n];
            end
        end else begin
            for (int n = 0; n < ternary_pkg::acc_count - 1; n++) begin
                queue_q[n] <= queue_q[n+1];
            end
        end
    end

    // scaled result, bits 15:8 of the head entry
    // top accumulator bit is dropped, so large sums wrap
    assign result_out = queue_q[0][ternary_pkg::result_shift +: ternary_pkg::byte_width];

endmodule

//--- verilog/ternary_matmul_top.sv
// Ternary matrix-vector top
`timescale 1ns/1ps

module ternary_matmul_top (
    input  logic                               clk,
    input  logic                               reset,
    input  logic [ternary_pkg::byte_width-1:0] weights_in,
    input  logic [ternary_pkg::byte_width-1:0] activations_in,
    input  logic                               compute,
    output logic [ternary_pkg::byte_width-1:0] result_out
);

    // decoded lanes of the current weight byte
    ternary_pkg::lane_mask_t weight_zero;
    ternary_pkg::lane_mask_t weight_sign;

    // stable frame handed from the stager to the array
    ternary_pkg::row_mask_t row_zero;
    ternary_pkg::row_mask_t row_sign;
    ternary_pkg::frame_t    frame;
    ternary_pkg::slice_t    slice;

    // updated accumulator values, shared by ring and readout
    ternary_pkg::acc_t acc_next [ternary_pkg::acc_count];

    // base-3 weight decode, purely combinational
    weight_unpacker u_weight_unpacker (
        .packed_weights (weights_in),
        .weight_zero    (weight_zero),
        .weight_sign    (weight_sign)
    );

    // gathers bytes into frames and double buffers them
    input_stager u_input_stager (
        .clk         (clk),
        .reset       (reset),
        .compute     (compute),
        .weight_zero (weight_zero),
        .weight_sign (weight_sign),
        .activation  (activations_in),
        .row_zero    (row_zero),
        .row_sign    (row_sign),
        .frame       (frame),
        .slice       (slice)
    );

    // rotating accumulator rings
    mac_array u_mac_array (
        .clk      (clk),
        .reset    (reset),
        .compute  (compute),
        .row_zero (row_zero),
        .row_sign (row_sign),
        .frame    (frame),
        .slice    (slice),
        .acc_next (acc_next)
    );

    // snapshot and serial readout
    readout_queue u_readout_queue (
        .clk        (clk),
        .reset      (reset),
        .compute    (compute),
        .acc_next   (acc_next),
        .result_out (result_out)
    );

endmodule

//--- tests/tb_tasks.svh
// Testbench tasks and model
`ifndef TB_TASKS_SVH
`define TB_TASKS_SVH

// compares one value and logs a mismatch in hex
task automatic check_value(input string name, input logic [31:0] actual,
                           input logic [31:0] expected);
    check_count++;
    if (actual !== expected) begin
        error_count++;
        $display("FAIL %s got 0x%0h expected 0x%0h at %0t", name, actual, expected, $time);
    end
endtask

// base-3 decode, digit k goes to lane 4-k, invalid codes give all +1
function automatic void decode_base3(input logic [7:0] code, output logic [4:0] zero,
                                     output logic [4:0] sign);
    int value;
    int digit;
    value = int'(code);
    zero = '0;
    sign = '0;
    if (value < 243) begin
        for (int k = 0; k < 5; k++) begin
            digit = value % 3;
            value = value / 3;
            zero[4-k] = (digit == 0);
            sign[4-k] = (digit == 2);
        end
    end
endfunction

// one clock of the register-level model
task automatic model_step();
    logic [4:0]        wz;
    logic [4:0]        ws;
    logic signed [7:0] act_s;
    model_acc_t        addend;
    model_acc_t        nxt [ternary_pkg::acc_count];
    int                base;
    int                cs;
    cs = ternary_pkg::compute_slices;
    decode_base3(weights_in, wz, ws);
    act_s = m_frame[m_slice];
    addend = model_acc_t'(act_s);
    // ring rotation, updated head lands in the last column
    for (int r = 0; r < ternary_pkg::array_rows; r++) begin
        base = r * cs;
        for (int c = 0; c < cs - 1; c++) begin
            nxt[base+c] = m_acc[base+c+1];
        end
        if (m_row_zero[r]) begin
            nxt[base+cs-1] = m_acc[base];
        end else if (m_row_sign[r]) begin
            nxt[base+cs-1] = m_acc[base] - addend;
        end else begin
            nxt[base+cs-1] = m_acc[base] + addend;
        end
    end
    for (int n = 0; n < ternary_pkg::acc_count; n++) begin
        if (reset) begin
            m_queue[n] = '0;
        end else if (!compute) begin
            m_queue[n] = nxt[n];
        end else if (n < ternary_pkg::acc_count - 1) begin
            m_queue[n] = m_queue[n+1];
        end
        m_acc[n] = (reset || !compute) ? model_acc_t'(0) : nxt[n];
    end
    // current frame takes the old fill-side contents at slice 0
    if (m_slice == 0) begin
        m_row_zero = m_next_zero;
        m_row_sign = m_next_sign;
        m_frame = m_next_frame;
    end
    if (reset) begin
        m_next_zero = '0;
        m_next_sign = '0;
        for (int b = 0; b < cs; b++) begin
            m_next_frame[b] = 8'h00;
        end
    end else begin
        for (int l = 0; l < 5; l++) begin
            m_next_zero[m_slice*5+l] = wz[l];
            m_next_sign[m_slice*5+l] = ws[l];
        end
        m_next_frame[m_slice] = activations_in;
    end
    if (reset || !compute || m_slice == cs - 1) begin
        m_slice = 0;
    end else begin
        m_slice = m_slice + 1;
    end
endtask

task automatic drive_cycle(input logic compute_v, input logic [7:0] code, input logic [7:0] act);
    @(posedge clk);
    compute <= compute_v;
    weights_in <= code;
    activations_in <= act;
endtask

task automatic drive_random(input logic compute_v);
    logic [7:0] code;
    logic [7:0] act;
    code = 8'($random(seed));
    act = 8'($random(seed));
    drive_cycle(compute_v, code, act);
endtask

// one low cycle, then every queue entry compared as it reaches the output
task automatic readout_and_compare(input logic [7:0] code, input logic [7:0] act,
                                   input logic expect_zero);
    drive_cycle(1'b0, code, act);
    for (int n = 0; n < ternary_pkg::acc_count; n++) begin
        drive_cycle(1'b1, code, act);
        @(negedge clk);
        check_value("result_out", 32'(result_out),
                    32'(m_queue[0][ternary_pkg::result_shift +: 8]));
        if (expect_zero) begin
            check_value("result_out", 32'(result_out), 32'h0);
        end
    end
endtask

task automatic report_test(input string name, input int errors_before);
    $display("test %s finished with %0d errors", name, error_count - errors_before);
endtask

task automatic idle_after_reset();
    int errors_before;
    errors_before = error_count;
    // queue only shifts zeros in while compute stays high
    for (int n = 0; n < idle_cycles; n++) begin
        drive_random(1'b1);
        @(negedge clk);
        check_value("result_out", 32'(result_out), 32'h0);
    end
    report_test("idle", errors_before);
endtask

task automatic decode_codes();
    logic [7:0] codes [6] = '{8'd0, 8'd1, 8'd2, 8'd121, 8'd242, 8'd250};
    logic [7:0] acts [2] = '{8'd1, 8'd64};
    int         errors_before;
    errors_before = error_count;
    // activation 64 pushes the sums past bit 8
    for (int a = 0; a < 2; a++) begin
        for (int c = 0; c < 6; c++) begin
            for (int n = 0; n < 6 * ternary_pkg::compute_slices; n++) begin
                drive_cycle(1'b1, codes[c], acts[a]);
            end
            readout_and_compare(codes[c], acts[a], 1'b0);
        end
    end
    report_test("decode", errors_before);
endtask

task automatic random_accumulate(input string name);
    int         errors_before;
    logic [7:0] code;
    logic [7:0] act;
    errors_before = error_count;
    for (int n = 0; n < 40; n++) begin
        drive_random(1'b1);
    end
    code = 8'($random(seed));
    act = 8'($random(seed));
    readout_and_compare(code, act, 1'b0);
    report_test(name, errors_before);
endtask

task automatic reload_hold();
    int errors_before;
    errors_before = error_count;
    // clear the rings, then build sums above 255 in every accumulator
    // all lanes +1 with activation 127 for ten edges
    drive_cycle(1'b0, 8'd121, 8'h7f);
    for (int n = 0; n < 10; n++) begin
        drive_cycle(1'b1, 8'd121, 8'h7f);
    end
    // two zero frames flush the staged activations
    for (int n = 0; n < 4; n++) begin
        drive_cycle(1'b1, 8'd0, 8'd0);
    end
    // first low cycle still captures the large sums
    // two low cycles here, the third comes from the readout
    drive_cycle(1'b0, 8'd0, 8'd0);
    drive_cycle(1'b0, 8'd0, 8'd0);
    readout_and_compare(8'd0, 8'd0, 1'b1);
    report_test("reload", errors_before);
endtask

`endif

//--- tests/tb_ternary_matmul.sv
// Ternary accelerator testbench
`timescale 1ns/1ps

module tb_ternary_matmul;

    // model accumulator type, same width as the design's
    typedef logic signed [ternary_pkg::acc_width-1:0] model_acc_t;

    // cycle budget per test, used by the watchdog
    localparam int reset_cycles = 4;
    localparam int readout_cycles = ternary_pkg::acc_count + 1;
    localparam int idle_cycles = 25;
    localparam int decode_cycles = 12 * (6 * ternary_pkg::compute_slices + readout_cycles);
    localparam int burst_cycles = 40 + readout_cycles;
    localparam int reload_cycles = 17 + readout_cycles;
    localparam int total_cycles = reset_cycles + idle_cycles + decode_cycles
                                  + 2 * burst_cycles + reload_cycles;

    logic       clk;
    logic       reset;
    logic [7:0] weights_in;
    logic [7:0] activations_in;
    logic       compute;
    logic [7:0] result_out;

    integer seed = 32'hf3e5f179;
    int     error_count = 0;
    int     check_count = 0;

    // reference model state, updated once per rising edge
    int                              m_slice = 0;
    logic [ternary_pkg::array_rows-1:0] m_next_zero;
    logic [ternary_pkg::array_rows-1:0] m_next_sign;
    logic [ternary_pkg::array_rows-1:0] m_row_zero;
    logic [ternary_pkg::array_rows-1:0] m_row_sign;
    logic [7:0]                      m_next_frame [ternary_pkg::compute_slices];
    logic [7:0]                      m_frame [ternary_pkg::compute_slices];
    model_acc_t                      m_acc [ternary_pkg::acc_count];
    model_acc_t                      m_queue [ternary_pkg::acc_count];

    ternary_matmul_top u_ternary_matmul_top (
        .clk            (clk),
        .reset          (reset),
        .weights_in     (weights_in),
        .activations_in (activations_in),
        .compute        (compute),
        .result_out     (result_out)
    );

    `include "tb_tasks.svh"

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    // model samples the same input values the DUT sees at this edge
    always @(posedge clk) begin
        model_step();
    end

    // watchdog, twice the planned run length
    initial begin
        #(total_cycles * 40 * 2);
        $display("watchdog expired before the test sequence completed");
        $display("Simulation FAILED");
        $finish;
    end

    initial begin
        reset <= 1'b1;
        compute <= 1'b0;
        weights_in <= 8'h00;
        activations_in <= 8'h00;
        repeat (reset_cycles) @(posedge clk);
        reset <= 1'b0;
        compute <= 1'b1;

        idle_after_reset();
        decode_codes();
        random_accumulate("accumulate");
        // second burst starts right after the first readout
        random_accumulate("clear");
        reload_hold();

        $display("checks %0d, errors %0d", check_count, error_count);
        if (error_count == 0) begin
            $display("Simulation PASSED");
        end else begin
            $display("Simulation FAILED");
        end
        $finish;
    end

endmodule

//--- flist.f
+incdir+tests
verilog/ternary_pkg.sv
verilog/weight_unpacker.sv
verilog/input_stager.sv
verilog/mac_array.sv
verilog/readout_queue.sv
verilog/ternary_matmul_top.sv
tests/tb_ternary_matmul.sv

//--- run.sh
#!/bin/sh
# build and run the ternary accelerator testbench with Verilator

log=sim.log

verilator --binary --timing -f flist.f --top-module tb_ternary_matmul -o sim_tb
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

./obj_dir/sim_tb > "$log" 2>&1
status=$?
cat "$log"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

# the log decides the verdict
if grep -q "Simulation FAILED" "$log"; then
    echo "failure reported in $log"
    exit 1
fi

exit 0
